//--- tb/adaptive_port_stimulus.txt
# op a b c, all hex. F=flit(payload,allow,credit) R=random flit(allow) C=credit(mask)
# I=idle(cycles) Q=ready probe(allow,exp_ready) W=write(addr,data,exp_err) D=read(addr,exp_data,exp_err)
I 2
# reset state
D 00 1F 0
D 04 0 0
D 08 0 0
# least loaded spread over all ports
F 1001 1F 0
R 1F
F 1003 1F 0
R 1F
F 1005 1F 0
F 1006 1F 0
R 1F
D 04 1252 0
D 08 7 0
# allow mask restricts the choice
F 2001 06 0
F 2002 0C 0
# ports 0 and 4 disabled in software
W 00 0E 0
F 2003 1F 0
Q 11 0
D 00 0E 0
W 00 1F 0
C 1F
# fill port 4 until it stalls
F 3001 10 0
F 3002 10 0
F 3003 10 0
F 3004 10 0
F 3005 10 0
F 3006 10 0
F 3007 10 0
Q 10 0
D 04 7251 0
C 10
Q 10 1
F 3008 10 0
Q 10 0
C 10
# grant and credit in one cycle
F 5A5A 10 10
D 04 6251 0
# grant counter and unmapped addresses
D 08 13 0
W 08 0 0
D 08 0 0
D 0C 0 1
W 10 5 1
D 00 1F 0
I 4

//--- adaptive_port_top.f
rtl/noc_router_pkg.sv
rtl/noc_apb_pkg.sv
rtl/noc_common.sv
rtl/occupancy_counter_bank.sv
rtl/min_load_port_sel.sv
rtl/port_sel_apb_regs.sv
rtl/adaptive_port_top.sv
tb/port_sel_checker.sv
tb/adaptive_port_tb.sv

//--- Bender.yml
package:
  name: adaptive_port

sources:
  - rtl/noc_router_pkg.sv
  - rtl/noc_apb_pkg.sv
  - rtl/noc_common.sv
  - rtl/occupancy_counter_bank.sv
  - rtl/min_load_port_sel.sv
  - rtl/port_sel_apb_regs.sv
  - rtl/adaptive_port_top.sv
  - target: test
    files:
      - tb/port_sel_checker.sv
      - tb/adaptive_port_tb.sv

//--- tb/adaptive_port_tb.sv
`timescale 1ns/1ps

module adaptive_port_tb;
    import noc_router_pkg::*;
    import noc_apb_pkg::*;

    localparam int    CLK_NS     = 100;
    localparam int    RST_CYCLES = 16;
    localparam string STIM_FILE  = "tb/adaptive_port_stimulus.txt";

    logic                  clk;
    logic                  rst;
    logic                  req_valid;
    flit_t                 req_flit;
    logic [NUM_PORTS-1:0]  req_allow;
    logic                  req_ready;
    logic                  out_valid;
    logic [NUM_PORTS-1:0]  out_port;
    logic [PORT_IDX_W-1:0] out_port_idx;
    flit_t                 out_flit;
    logic [NUM_PORTS-1:0]  credit;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [APB_AW-1:0]     paddr;
    logic [APB_DW-1:0]     pwdata;
    logic [APB_DW-1:0]     prdata;
    logic                  pready;
    logic                  pslverr;

    logic [7:0]  cmd_op [$];                        // one entry per stimulus line
    logic [31:0] cmd_a [$];
    logic [31:0] cmd_b [$];
    logic [31:0] cmd_c [$];
    bit          loaded = 1'b0;
    integer      seed;
    int          tb_errors = 0;
    int          chk_errors;

    initial clk = 1'b0;
    always #(CLK_NS / 2) clk = ~clk;

    adaptive_port_top DUT (
        .clk            (clk),
        .rst_i          (rst),
        .req_valid_i    (req_valid),
        .req_flit_i     (req_flit),
        .req_allow_i    (req_allow),
        .req_ready_o    (req_ready),
        .out_valid_o    (out_valid),
        .out_port_o     (out_port),
        .out_port_idx_o (out_port_idx),
        .out_flit_o     (out_flit),
        .credit_i       (credit),
        .psel_i         (psel),
        .penable_i      (penable),
        .pwrite_i       (pwrite),
        .paddr_i        (paddr),
        .pwdata_i       (pwdata),
        .prdata_o       (prdata),
        .pready_o       (pready),
        .pslverr_o      (pslverr)
    );

    port_sel_checker u_chk (
        .clk            (clk),
        .rst_i          (rst),
        .req_valid_i    (req_valid),
        .req_flit_i     (req_flit),
        .req_allow_i    (req_allow),
        .req_ready_i    (req_ready),
        .out_valid_i    (out_valid),
        .out_port_i     (out_port),
        .out_port_idx_i (out_port_idx),
        .out_flit_i     (out_flit),
        .credit_i       (credit),
        .psel_i         (psel),
        .penable_i      (penable),
        .pwrite_i       (pwrite),
        .paddr_i        (paddr),
        .pwdata_i       (pwdata),
        .prdata_i       (prdata),
        .pslverr_i      (pslverr),
        .err_cnt_o      (chk_errors)
    );

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("mismatch %s at %0t ns: got 0x%0h, expected 0x%0h", name, $time, got, exp);
            tb_errors++;
        end
    endtask

    task automatic drive_defaults();
        req_valid = 1'b0;
        req_allow = '0;
        credit    = '0;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
    endtask

    task automatic load_commands();
        int          fd;
        int          rc;
        int          n_arg;
        int          ch;
        logic [7:0]  op;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            $display("cannot open stimulus file %s", STIM_FILE);
            tb_errors++;
        end else begin
            while ($fscanf(fd, " %c", op) == 1) begin
                a     = '0;
                b     = '0;
                c     = '0;
                rc    = 0;
                n_arg = 0;
                case (op)
                    "#": begin
                        ch = $fgetc(fd);
                        while (ch != 10 && ch != -1) begin
                            ch = $fgetc(fd);
                        end
                    end
                    "F", "W", "D": begin
                        rc    = $fscanf(fd, "%h %h %h", a, b, c);
                        n_arg = 3;
                    end
                    "Q": begin
                        rc    = $fscanf(fd, "%h %h", a, b);
                        n_arg = 2;
                    end
                    default: begin
                        rc    = $fscanf(fd, "%h", a);
                        n_arg = 1;
                    end
                endcase
                if (op != "#") begin
                    if (rc != n_arg) begin
                        $display("stimulus command '%c' has %0d of its %0d fields",
                                 op, rc, n_arg);
                        tb_errors++;
                    end
                    cmd_op.push_back(op);
                    cmd_a.push_back(a);
                    cmd_b.push_back(b);
                    cmd_c.push_back(c);
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic idle_cycles(input logic [31:0] n);
        repeat (n) begin
            @(negedge clk);
            drive_defaults();
            @(posedge clk);
        end
    endtask

    // credit only rides along in the first cycle of the request
    task automatic send_flit(input logic [31:0] payload, input logic [31:0] allow,
                             input logic [31:0] cr);
        @(negedge clk);
        drive_defaults();
        req_valid = 1'b1;
        req_flit  = payload[FLIT_W-1:0];
        req_allow = allow[NUM_PORTS-1:0];
        credit    = cr[NUM_PORTS-1:0];
        @(posedge clk);
        while (!req_ready) begin
            @(negedge clk);
            credit = '0;
            @(posedge clk);
        end
    endtask

    task automatic send_credit(input logic [31:0] mask);
        @(negedge clk);
        drive_defaults();
        credit = mask[NUM_PORTS-1:0];
        @(posedge clk);
    endtask

    task automatic probe_ready(input logic [31:0] allow, input logic [31:0] exp_ready);
        @(negedge clk);
        drive_defaults();
        req_allow = allow[NUM_PORTS-1:0];           // valid stays low, nothing is granted
        @(posedge clk);
        compare("req_ready_o", req_ready, exp_ready);
    endtask

    task automatic apb_write(input logic [31:0] addr, input logic [31:0] data,
                             input logic [31:0] exp_err);
        @(negedge clk);
        drive_defaults();
        psel   = 1'b1;
        pwrite = 1'b1;
        paddr  = addr[APB_AW-1:0];
        pwdata = data;
        @(negedge clk);
        penable = 1'b1;
        @(posedge clk);
        compare("pready_o", pready, 32'd1);
        compare("pslverr_o", pslverr, exp_err);
    endtask

    task automatic apb_read(input logic [31:0] addr, input logic [31:0] exp_data,
                            input logic [31:0] exp_err);
        @(negedge clk);
        drive_defaults();
        psel  = 1'b1;
        paddr = addr[APB_AW-1:0];
        @(negedge clk);
        penable = 1'b1;
        @(posedge clk);
        compare("pready_o", pready, 32'd1);
        compare("prdata_o", prdata, exp_data);
        compare("pslverr_o", pslverr, exp_err);
    endtask

    initial begin : main
        logic [31:0] rnd;
        rst      = 1'b1;
        req_flit = '0;
        paddr    = '0;
        pwdata   = '0;
        drive_defaults();
        seed = 32'hd36ebd89;
        load_commands();
        loaded = 1'b1;
        repeat (RST_CYCLES) @(negedge clk);
        rst = 1'b0;
        foreach (cmd_op[k]) begin
            case (cmd_op[k])
                "F": send_flit(cmd_a[k], cmd_b[k], cmd_c[k]);
                "R": begin
                    rnd = $random(seed);
                    send_flit(rnd, cmd_a[k], 32'd0);
                end
                "C": send_credit(cmd_a[k]);
                "I": idle_cycles(cmd_a[k]);
                "Q": probe_ready(cmd_a[k], cmd_b[k]);
                "W": apb_write(cmd_a[k], cmd_b[k], cmd_c[k]);
                "D": apb_read(cmd_a[k], cmd_b[k], cmd_c[k]);
                default: begin
                    $display("unknown stimulus command '%c'", cmd_op[k]);
                    tb_errors++;
                end
            endcase
        end
        idle_cycles(2);                             // last flit still in the output register
        @(negedge clk);
        $display("errors: checker %0d, testbench %0d", chk_errors, tb_errors);
        if (chk_errors == 0 && tb_errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    // 20 clock periods per command on top of the reset phase
    initial begin : watchdog
        longint limit_ns;
        wait (loaded);
        limit_ns = (longint'(cmd_op.size()) * 20 + RST_CYCLES) * CLK_NS;
        #(limit_ns);
        $display("timeout: stimulus did not finish within %0d ns", limit_ns);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

//--- tb/port_sel_checker.sv
`timescale 1ns/1ps

module port_sel_checker (
    input  logic                                  clk,
    input  logic                                  rst_i,
    input  logic                                  req_valid_i,
    input  noc_router_pkg::flit_t                 req_flit_i,
    input  logic [noc_router_pkg::NUM_PORTS-1:0]  req_allow_i,
    input  logic                                  req_ready_i,
    input  logic                                  out_valid_i,
    input  logic [noc_router_pkg::NUM_PORTS-1:0]  out_port_i,
    input  logic [noc_router_pkg::PORT_IDX_W-1:0] out_port_idx_i,
    input  noc_router_pkg::flit_t                 out_flit_i,
    input  logic [noc_router_pkg::NUM_PORTS-1:0]  credit_i,
    input  logic                                  psel_i,
    input  logic                                  penable_i,
    input  logic                                  pwrite_i,
    input  logic [noc_apb_pkg::APB_AW-1:0]        paddr_i,
    input  logic [noc_apb_pkg::APB_DW-1:0]        pwdata_i,
    input  logic [noc_apb_pkg::APB_DW-1:0]        prdata_i,
    input  logic                                  pslverr_i,
    output int                                    err_cnt_o
);
    import noc_router_pkg::*;
    import noc_apb_pkg::*;

    int unsigned            count [NUM_PORTS];      // flits in flight per port
    logic [NUM_PORTS-1:0]   en_model;
    logic [GRANT_CNT_W-1:0] grants_model;
    logic                   pend_valid;             // grant seen in the previous cycle
    int                     pend_port;
    flit_t                  pend_flit;
    int                     errors = 0;

    assign err_cnt_o = errors;

    task automatic check_equal(
        input string       name,
        input logic [31:0] got,
        input logic [31:0] exp
    );
        if (got !== exp) begin
            $display("mismatch %s at %0t ns: got 0x%0h, expected 0x%0h", name, $time, got, exp);
            errors++;
        end
    endtask

    // lowest count wins, strict compare keeps the lower index on ties
    function automatic int least_loaded(input logic [NUM_PORTS-1:0] elig);
        int best;
        best = -1;
        for (int i = 0; i < NUM_PORTS; i++) begin
            if (elig[i] && (best < 0 || count[i] < count[best])) begin
                best = i;
            end
        end
        return best;
    endfunction

    always @(posedge clk) begin : track
        logic [NUM_PORTS-1:0] elig;
        logic [APB_DW-1:0]    occ_packed;
        logic                 mapped;
        logic                 grant_now;
        logic                 apb_access;
        int                   sel;
        if (rst_i) begin
            for (int i = 0; i < NUM_PORTS; i++) begin
                count[i] = 0;
            end
            en_model     = '1;
            grants_model = '0;
            pend_valid   = 1'b0;
        end else begin
            check_equal("out_valid_o", out_valid_i, pend_valid);
            if (pend_valid) begin
                check_equal("out_port_o", out_port_i, 32'(1) << pend_port);
                check_equal("out_port_idx_o", out_port_idx_i, pend_port);
                check_equal("out_flit_o", out_flit_i, pend_flit);
            end

            occ_packed = '0;
            for (int i = 0; i < NUM_PORTS; i++) begin
                elig[i] = req_allow_i[i] && en_model[i] && count[i] < PORT_DEPTH;
                occ_packed[i*CNT_W +: CNT_W] = CNT_W'(count[i]);
            end
            check_equal("req_ready_o", req_ready_i, |elig);

            sel        = least_loaded(elig);
            grant_now  = req_valid_i && sel >= 0;
            pend_valid = grant_now;
            pend_port  = sel;
            pend_flit  = req_flit_i;

            apb_access = psel_i && penable_i;
            if (apb_access) begin
                mapped = paddr_i == REG_PORT_EN || paddr_i == REG_OCC || paddr_i == REG_GRANTS;
                check_equal("pslverr_o", pslverr_i, !mapped);
                if (!pwrite_i && paddr_i == REG_PORT_EN) begin
                    check_equal("prdata_o", prdata_i, en_model);
                end else if (!pwrite_i && paddr_i == REG_OCC) begin
                    check_equal("prdata_o", prdata_i, occ_packed);
                end else if (!pwrite_i && paddr_i == REG_GRANTS) begin
                    check_equal("prdata_o", prdata_i, grants_model);
                end
                if (pwrite_i && paddr_i == REG_PORT_EN) begin
                    en_model = pwdata_i[NUM_PORTS-1:0];     // counts from the next cycle
                end
            end

            if (apb_access && pwrite_i && paddr_i == REG_GRANTS) begin
                grants_model = '0;                          // clear wins over a grant
            end else if (grant_now) begin
                grants_model = grants_model + 1'b1;
            end

            for (int i = 0; i < NUM_PORTS; i++) begin
                if (credit_i[i] && count[i] == 0) begin
                    $display("credit returned on port %0d with no flit in flight at %0t ns",
                             i, $time);
                    errors++;
                end else if (credit_i[i] && !(grant_now && sel == i)) begin
                    count[i]--;
                end else if (!credit_i[i] && grant_now && sel == i) begin
                    count[i]++;
                end
            end
        end
    end

endmodule

//--- rtl/adaptive_port_top.sv
`timescale 1ns/1ps

module adaptive_port_top (
    input  logic                                  clk,
    input  logic                                  rst_i,
    // flit request
    input  logic                                  req_valid_i,
    input  noc_router_pkg::flit_t                 req_flit_i,
    input  logic [noc_router_pkg::NUM_PORTS-1:0]  req_allow_i,
    output logic                                  req_ready_o,
    // selected output
    output logic                                  out_valid_o,
    output logic [noc_router_pkg::NUM_PORTS-1:0]  out_port_o,
    output logic [noc_router_pkg::PORT_IDX_W-1:0] out_port_idx_o,
    output noc_router_pkg::flit_t                 out_flit_o,
    input  logic [noc_router_pkg::NUM_PORTS-1:0]  credit_i,
    // register bus
    input  logic                                  psel_i,
    input  logic                                  penable_i,
    input  logic                                  pwrite_i,
    input  logic [noc_apb_pkg::APB_AW-1:0]        paddr_i,
    input  logic [noc_apb_pkg::APB_DW-1:0]        pwdata_i,
    output logic [noc_apb_pkg::APB_DW-1:0]        prdata_o,
    output logic                                  pready_o,
    output logic                                  pslverr_o
);
    import noc_router_pkg::*;

    logic [NUM_PORTS-1:0] grant;
    logic [NUM_PORTS-1:0] full;
    logic [NUM_PORTS-1:0] port_en;
    logic [OCC_W-1:0]     occ;

    min_load_port_sel u_sel (
        .clk            (clk),
        .rst_i          (rst_i),
        .req_valid_i    (req_valid_i),
        .req_flit_i     (req_flit_i),
        .req_allow_i    (req_allow_i),
        .port_en_i      (port_en),
        .occ_i          (occ),
        .full_i         (full),
        .req_ready_o    (req_ready_o),
        .grant_o        (grant),
        .out_valid_o    (out_valid_o),
        .out_port_o     (out_port_o),
        .out_port_idx_o (out_port_idx_o),
        .out_flit_o     (out_flit_o)
    );

    occupancy_counter_bank u_occ (
        .clk      (clk),
        .rst_i    (rst_i),
        .grant_i  (grant),
        .credit_i (credit_i),
        .occ_o    (occ),
        .full_o   (full)
    );

    port_sel_apb_regs u_regs (
        .clk           (clk),
        .rst_i         (rst_i),
        .psel_i        (psel_i),
        .penable_i     (penable_i),
        .pwrite_i      (pwrite_i),
        .paddr_i       (paddr_i),
        .pwdata_i      (pwdata_i),
        .prdata_o      (prdata_o),
        .pready_o      (pready_o),
        .pslverr_o     (pslverr_o),
        .grant_pulse_i (|grant),                    // one grant per cycle at most
        .occ_i         (occ),
        .port_en_o     (port_en)
    );

endmodule

//--- rtl/port_sel_apb_regs.sv
`timescale 1ns/1ps

module port_sel_apb_regs (
    input  logic                                 clk,
    input  logic                                 rst_i,
    input  logic                                 psel_i,
    input  logic                                 penable_i,
    input  logic                                 pwrite_i,
    input  logic [noc_apb_pkg::APB_AW-1:0]       paddr_i,
    input  logic [noc_apb_pkg::APB_DW-1:0]       pwdata_i,
    output logic [noc_apb_pkg::APB_DW-1:0]       prdata_o,
    output logic                                 pready_o,
    output logic                                 pslverr_o,
    input  logic                                 grant_pulse_i,
    input  logic [noc_router_pkg::OCC_W-1:0]     occ_i,
    output logic [noc_router_pkg::NUM_PORTS-1:0] port_en_o
);
    import noc_router_pkg::*;
    import noc_apb_pkg::*;

    logic                   access;
    logic                   hit_en;
    logic                   hit_occ;
    logic                   hit_grants;
    logic                   mapped;
    logic [NUM_PORTS-1:0]   port_en_q;
    logic [GRANT_CNT_W-1:0] grant_cnt_q;

    assign access     = psel_i & penable_i;         // ACCESS phase
    assign hit_en     = paddr_i == REG_PORT_EN;
    assign hit_occ    = paddr_i == REG_OCC;
    assign hit_grants = paddr_i == REG_GRANTS;
    assign mapped     = hit_en | hit_occ | hit_grants;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            port_en_q   <= PORT_EN_RST;
            grant_cnt_q <= GRANT_RST;
        end else begin
            if (access && pwrite_i && hit_en) begin
                port_en_q <= pwdata_i[NUM_PORTS-1:0];
            end
            if (access && pwrite_i && hit_grants) begin
                grant_cnt_q <= '0;                  // clear beats a same-cycle grant
            end else if (grant_pulse_i) begin
                grant_cnt_q <= grant_cnt_q + 1'b1;  // wraps
            end
        end
    end

    always_comb begin
        prdata_o = '0;
        if (hit_en) begin
            prdata_o = APB_DW'(port_en_q);
        end else if (hit_occ) begin
            prdata_o = APB_DW'(occ_i);              // live counts
        end else if (hit_grants) begin
            prdata_o = APB_DW'(grant_cnt_q);
        end
    end

    assign pready_o  = 1'b1;                        // no wait states
    assign pslverr_o = access & ~mapped;
    assign port_en_o = port_en_q;

    a_penable_in_psel : assert property (
        @(posedge clk) disable iff (rst_i) penable_i |-> psel_i
    ) else $error("APB penable high without psel");

    // every SETUP cycle is followed by its ACCESS cycle
    a_setup_then_access : assert property (
        @(posedge clk) disable iff (rst_i) (psel_i && !penable_i) |=> (psel_i && penable_i)
    ) else $error("APB SETUP phase not followed by ACCESS");

endmodule

//--- rtl/min_load_port_sel.sv
`timescale 1ns/1ps

module min_load_port_sel (
    input  logic                                  clk,
    input  logic                                  rst_i,
    input  logic                                  req_valid_i,
    input  noc_router_pkg::flit_t                 req_flit_i,
    input  logic [noc_router_pkg::NUM_PORTS-1:0]  req_allow_i,
    input  logic [noc_router_pkg::NUM_PORTS-1:0]  port_en_i,
    input  logic [noc_router_pkg::OCC_W-1:0]      occ_i,
    input  logic [noc_router_pkg::NUM_PORTS-1:0]  full_i,
    output logic                                  req_ready_o,
    output logic [noc_router_pkg::NUM_PORTS-1:0]  grant_o,
    output logic                                  out_valid_o,
    output logic [noc_router_pkg::NUM_PORTS-1:0]  out_port_o,
    output logic [noc_router_pkg::PORT_IDX_W-1:0] out_port_idx_o,
    output noc_router_pkg::flit_t                 out_flit_o
);
    import noc_router_pkg::*;

    logic [NUM_PORTS-1:0]  eligible;
    logic [CNT_W:0]        load [NUM_PORTS];        // one extra bit for the blocked value
    logic [NUM_PORTS-1:0]  min_sel;
    logic [PORT_IDX_W-1:0] grant_idx;
    flit_t                 flit_fan [NUM_PORTS];
    flit_t                 flit_gated;

    logic                  out_valid_q;
    logic [NUM_PORTS-1:0]  out_port_q;
    logic [PORT_IDX_W-1:0] out_port_idx_q;
    flit_t                 out_flit_q;

    assign eligible = req_allow_i & port_en_i & ~full_i;

    always_comb begin
        for (int i = 0; i < NUM_PORTS; i++) begin
            // blocked ports sit one above the largest count
            load[i]     = eligible[i] ? {1'b0, occ_i[i*CNT_W +: CNT_W]}
                                      : {1'b1, {CNT_W{1'b0}}};
            flit_fan[i] = req_flit_i;
        end
    end

    fast_minimum_number u_min (
        .values_i (load),
        .min_o    (min_sel)
    );

    assign req_ready_o = |eligible;
    assign grant_o     = min_sel & {NUM_PORTS{req_valid_i & req_ready_o}};

    one_hot_to_bin u_idx (
        .one_hot_i (grant_o),
        .bin_o     (grant_idx)
    );

    // payload comes through only on a grant, zero otherwise
    one_hot_mux #(
        .payload_t (flit_t)
    ) u_flit_mux (
        .sel_i  (grant_o),
        .data_i (flit_fan),
        .data_o (flit_gated)
    );

    always_ff @(posedge clk) begin
        if (rst_i) begin
            out_valid_q <= 1'b0;
            out_port_q  <= '0;
        end else begin
            out_valid_q <= |grant_o;
            out_port_q  <= grant_o;
        end
    end

    always_ff @(posedge clk) begin
        out_port_idx_q <= grant_idx;
        out_flit_q     <= flit_gated;
    end

    assign out_valid_o    = out_valid_q;
    assign out_port_o     = out_port_q;
    assign out_port_idx_o = out_port_idx_q;
    assign out_flit_o     = out_flit_q;

    // relies on the tie break inside fast_minimum_number
    a_grant_onehot0 : assert property (
        @(posedge clk) disable iff (rst_i) $onehot0(grant_o)
    ) else $error("more than one output port granted in one cycle");

endmodule

//--- rtl/occupancy_counter_bank.sv
`timescale 1ns/1ps

module occupancy_counter_bank (
    input  logic                                 clk,
    input  logic                                 rst_i,
    input  logic [noc_router_pkg::NUM_PORTS-1:0] grant_i,
    input  logic [noc_router_pkg::NUM_PORTS-1:0] credit_i,
    output logic [noc_router_pkg::OCC_W-1:0]     occ_o,
    output logic [noc_router_pkg::NUM_PORTS-1:0] full_o
);
    import noc_router_pkg::*;

    logic [CNT_W-1:0]     cnt_q [NUM_PORTS];
    logic [NUM_PORTS-1:0] empty;

    always_comb begin
        for (int i = 0; i < NUM_PORTS; i++) begin
            occ_o[i*CNT_W +: CNT_W] = cnt_q[i];
            full_o[i]               = cnt_q[i] == CNT_W'(PORT_DEPTH);
            empty[i]                = cnt_q[i] == '0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int i = 0; i < NUM_PORTS; i++) begin
                cnt_q[i] <= '0;
            end
        end else begin
            for (int i = 0; i < NUM_PORTS; i++) begin
                // grant and credit together cancel out
                if (grant_i[i] && !credit_i[i] && !full_o[i]) begin
                    cnt_q[i] <= cnt_q[i] + 1'b1;
                end else if (credit_i[i] && !grant_i[i] && !empty[i]) begin
                    cnt_q[i] <= cnt_q[i] - 1'b1;
                end
            end
        end
    end

    // downstream can only return a slot it was given
    a_no_credit_when_empty : assert property (
        @(posedge clk) disable iff (rst_i) (credit_i & empty) == '0
    ) else $error("credit returned to a port with no flit in flight");

    // the selector must hold off full ports
    a_no_grant_when_full : assert property (
        @(posedge clk) disable iff (rst_i) (grant_i & full_o) == '0
    ) else $error("flit granted to a full port");

endmodule

//--- rtl/noc_common.sv
`timescale 1ns/1ps

module one_hot_mux #(
    parameter type payload_t = logic [7:0]
) (
    input  logic [noc_router_pkg::NUM_PORTS-1:0] sel_i,
    input  payload_t                             data_i [noc_router_pkg::NUM_PORTS],
    output payload_t                             data_o
);
    import noc_router_pkg::*;

    always_comb begin
        data_o = '0;
        for (int i = 0; i < NUM_PORTS; i++) begin
            if (sel_i[i]) begin
                data_o = data_o | data_i[i];        // and-or tree, no priority
            end
        end
    end

endmodule


module one_hot_to_bin (
    input  logic [noc_router_pkg::NUM_PORTS-1:0]  one_hot_i,
    output logic [noc_router_pkg::PORT_IDX_W-1:0] bin_o
);
    import noc_router_pkg::*;

    typedef logic [PORT_IDX_W-1:0] idx_t;

    idx_t idx_tbl [NUM_PORTS];                      // entry i holds constant i

    always_comb begin
        for (int i = 0; i < NUM_PORTS; i++) begin
            idx_tbl[i] = idx_t'(i);
        end
    end

    one_hot_mux #(
        .payload_t (idx_t)
    ) u_idx_mux (
        .sel_i  (one_hot_i),
        .data_i (idx_tbl),
        .data_o (bin_o)                             // zero when nothing is selected
    );

endmodule


module fast_minimum_number (
    input  logic [noc_router_pkg::CNT_W:0]       values_i [noc_router_pkg::NUM_PORTS],
    output logic [noc_router_pkg::NUM_PORTS-1:0] min_o
);
    import noc_router_pkg::*;

    // row i compares entry i against every other entry
    // column j stands for entry j below the diagonal and entry j+1 above it
    wire [NUM_PORTS-2:0] le_mat [NUM_PORTS];

    for (genvar i = 0; i < NUM_PORTS; i++) begin : g_row
        for (genvar j = 0; j < NUM_PORTS - 1; j++) begin : g_col
            if (i > j) begin : g_low
                // mirror of the upper half, strict compare
                assign le_mat[i][j] = ~le_mat[j][i-1];
            end else begin : g_up
                assign le_mat[i][j] = values_i[i] <= values_i[j+1];  // ties go to i
            end
        end
        assign min_o[i] = &le_mat[i];               // beats or ties all others
    end

endmodule

//--- rtl/noc_apb_pkg.sv
package noc_apb_pkg;

    localparam int APB_AW      = 8;
    localparam int APB_DW      = 32;
    localparam int GRANT_CNT_W = 16;

    // register map
    localparam logic [APB_AW-1:0] REG_PORT_EN = APB_AW'(8'h00);  // rw, one bit per port
    localparam logic [APB_AW-1:0] REG_OCC     = APB_AW'(8'h04);  // ro, packed counts
    localparam logic [APB_AW-1:0] REG_GRANTS  = APB_AW'(8'h08);  // any write clears

    // reset values
    localparam logic [noc_router_pkg::NUM_PORTS-1:0] PORT_EN_RST = '1;  // all ports on
    localparam logic [GRANT_CNT_W-1:0]               GRANT_RST   = '0;

endpackage

//--- rtl/noc_router_pkg.sv
package noc_router_pkg;

    // router geometry
    localparam int NUM_PORTS  = 5;
    localparam int PORT_IDX_W = 3;                  // binary index of one output port

    // flit payload
    localparam int FLIT_W     = 16;

    // downstream buffering, one credit per slot
    localparam int PORT_DEPTH = 7;
    localparam int CNT_W      = 3;                  // holds 0 .. PORT_DEPTH

    // all counts side by side, port 0 in the lowest field
    localparam int OCC_W      = NUM_PORTS * CNT_W;

    typedef logic [FLIT_W-1:0] flit_t;

endpackage
